// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := fetch_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# a failing run exits non-zero, so make fails with it
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+sim
source/fetch_pkg.sv
source/inst_ram.sv
source/wb_arbiter.sv
source/fetch_queue.sv
source/fetch_unit.sv
source/fetch_top.sv
sim/fetch_tb.sv

// ==== sim/fetch_ref.svh ====
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// copy of everything the loader wrote into the ram
xlen_t model_mem [RAM_WORDS];

// galois lfsr, x^32 + x^22 + x^2 + x + 1, right shifting
xlen_t lfsr_state = 32'h205a0610;

// one step, one bit out
function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
endfunction

// n fresh bits, first bit ends up as msb
function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[XLEN-2:0], lfsr_bit()};
    end
    return v;
endfunction

// expected decode item for a pc on the current path
function automatic fetch_item_t ref_item(input xlen_t pc, input logic redirected);
    fetch_item_t it;
    it.pc         = pc;
    // word index from byte address, wraps over the ram
    it.instr      = model_mem[pc[RAM_ADDR_W+1:2]];
    it.redirected = redirected;
    return it;
endfunction

`endif

// ==== sim/fetch_tb.sv ====
module fetch_tb import fetch_pkg::*; ();

    typedef logic [$bits(fetch_item_t)-1:0] cmp_t;

    localparam int CHECK_WORDS    = 64;
    localparam int SEQ_ITEMS      = 100;
    localparam int BP_ITEMS       = 200;
    localparam int FULL_CYCLES    = 30;
    localparam int DRAIN_ITEMS    = 20;
    localparam int REDIRECTS      = 20;
    localparam int REDIRECT_ITEMS = 8;
    localparam int ITEMS = SEQ_ITEMS + BP_ITEMS + DRAIN_ITEMS + REDIRECTS * REDIRECT_ITEMS;
    // 3 cycles per loader access or item plus up to 16 stall cycles per redirect, all doubled
    localparam int TIMEOUT_CYCLES =
        2 * (3 * (RAM_WORDS + CHECK_WORDS) + 3 * ITEMS + FULL_CYCLES + 16 * REDIRECTS);

    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    redirect_t   redirect;
    wb_req_t     load_req;
    logic        item_ready;
    wb_rsp_t     load_rsp;
    logic        item_valid;
    fetch_item_t item;

    // where decode expects the next item
    xlen_t exp_pc    = RESET_PC;
    logic  exp_redir = 1'b0;
    int    transfers = 0;
    int    cycles    = 0;
    string test_name;

    `include "fetch_ref.svh"

    fetch_top uut (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .redirect   (redirect),
        .load_req   (load_req),
        .item_ready (item_ready),
        .load_rsp   (load_rsp),
        .item_valid (item_valid),
        .item       (item)
    );

    always #2 clk = ~clk;

    task automatic compare_values(input string name, input cmp_t expected, input cmp_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "%s: value mismatch", name);
        end
    endtask

    // one wishbone classic cycle on the loader port
    task automatic bus_access(input logic we, input xlen_t adr, input xlen_t wdata,
                              output xlen_t rdata);
        @(posedge clk);
        #1;
        load_req.cyc = 1'b1;
        load_req.stb = 1'b1;
        load_req.we  = we;
        load_req.adr = adr;
        load_req.dat = wdata;
        load_req.sel = '1;
        @(negedge clk);
        while (!load_rsp.ack) begin
            @(negedge clk);
        end
        rdata = load_rsp.dat;
        // drop the cycle right after ack
        @(posedge clk);
        #1;
        load_req = '0;
    endtask

    // one-cycle redirect pulse to a new fetch target
    task automatic send_redirect(input xlen_t target);
        @(posedge clk);
        #1;
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(posedge clk);
        #1;
        redirect = '0;
    endtask

    // keep decode going until n more items were taken
    task automatic run_transfers(input int n, input logic random_ready);
        int target;
        target = transfers + n;
        while (transfers < target) begin
            @(posedge clk);
            #1;
            item_ready = random_ready ? lfsr_bit() : 1'b1;
        end
    endtask

    // decode side sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (item_valid && item_ready) begin
                compare_values(test_name, cmp_t'(ref_item(exp_pc, exp_redir)), cmp_t'(item));
                exp_pc    = exp_pc + PC_STEP;
                exp_redir = 1'b0;
                transfers = transfers + 1;
            end
            // old path ends here and the target comes next
            if (redirect.valid) begin
                exp_pc    = redirect.target;
                exp_redir = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Regression failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    initial begin
        xlen_t data;
        xlen_t rdata;
        xlen_t target;
        int    gap;
        logic  seen;

        rst        = 1'b1;
        run        = 1'b0;
        redirect   = '0;
        load_req   = '0;
        item_ready = 1'b0;
        test_name  = "reset";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        compare_values(test_name, cmp_t'(0), cmp_t'(item_valid));
        compare_values(test_name, cmp_t'(0), cmp_t'(load_rsp.ack));

        // loader writes then reads back while fetch is halted
        test_name = "load_readback";
        for (int i = 0; i < CHECK_WORDS; i++) begin
            data = rand_bits(XLEN);
            model_mem[i] = data;
            bus_access(1'b1, xlen_t'(i * 4), data, rdata);
        end
        for (int i = 0; i < CHECK_WORDS; i++) begin
            bus_access(1'b0, xlen_t'(i * 4), '0, rdata);
            compare_values(test_name, cmp_t'(model_mem[i]), cmp_t'(rdata));
        end
        // rest of the ram too since redirect targets land anywhere
        for (int i = CHECK_WORDS; i < RAM_WORDS; i++) begin
            data = rand_bits(XLEN);
            model_mem[i] = data;
            bus_access(1'b1, xlen_t'(i * 4), data, rdata);
        end

        test_name = "sequential";
        @(posedge clk);
        #1;
        run        = 1'b1;
        item_ready = 1'b1;
        run_transfers(SEQ_ITEMS, 1'b0);

        test_name = "back_pressure";
        run_transfers(BP_ITEMS, 1'b1);

        test_name = "queue_full";
        @(posedge clk);
        #1;
        item_ready = 1'b0;
        seen = 1'b0;
        repeat (FULL_CYCLES) begin
            @(negedge clk);
            // once up valid holds while decode stalls
            if (seen) begin
                compare_values(test_name, cmp_t'(1), cmp_t'(item_valid));
            end
            seen = seen | item_valid;
        end
        compare_values(test_name, cmp_t'(1), cmp_t'(item_valid));
        run_transfers(DRAIN_ITEMS, 1'b0);

        test_name = "redirect";
        for (int i = 0; i < REDIRECTS; i++) begin
            target = rand_bits(XLEN - 2) << 2;
            if (i % 2 == 1) begin
                // decode stalled long enough for a full queue
                @(posedge clk);
                #1;
                item_ready = 1'b0;
                repeat (12) @(posedge clk);
                send_redirect(target);
            end else if (i % 4 == 2) begin
                // loader read wins the bus so the fetch read still waits
                // for its ack when the redirect arrives
                item_ready = 1'b1;
                fork
                    bus_access(1'b0, target, '0, rdata);
                    begin
                        repeat (2) @(posedge clk);
                        send_redirect(target);
                    end
                join
                compare_values(test_name,
                               cmp_t'(model_mem[target[RAM_ADDR_W+1:2]]),
                               cmp_t'(rdata));
            end else begin
                // random spot in the fetch loop with a read in flight or idle
                gap = int'(rand_bits(3));
                repeat (gap) @(posedge clk);
                send_redirect(target);
            end
            run_transfers(REDIRECT_ITEMS, 1'b1);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // machine word, used for pc and instruction
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] xlen_t;

    // instruction ram geometry, word indexed
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = 8;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    // fetch queue geometry, depth is a power of two
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;
    typedef logic [QUEUE_PTR_W-1:0] qptr_t;
    // one extra bit so a full queue is representable
    typedef logic [QUEUE_PTR_W:0]   qcount_t;

    // program counter behaviour
    localparam xlen_t RESET_PC = 32'h0000_0000;
    localparam xlen_t PC_STEP  = 32'd4;

    // wishbone byte selects
    localparam int WB_SEL_W = 4;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // wishbone classic request, master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        xlen_t   adr;
        xlen_t   dat;
        wb_sel_t sel;
    } wb_req_t;

    // wishbone classic response, slave to master
    typedef struct packed {
        logic  ack;
        xlen_t dat;
    } wb_rsp_t;

    // taken branch or jump from a later stage
    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

    // one entry handed to decode
    typedef struct packed {
        xlen_t pc;
        xlen_t instr;
        logic  redirected;
    } fetch_item_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        DROP
    } fetch_state_t;

endpackage

// ==== source/fetch_queue.sv ====
module fetch_queue import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        push,
    input  fetch_item_t push_item,
    input  logic        item_ready,
    output logic        space,
    output logic        item_valid,
    output fetch_item_t item
);

    fetch_item_t mem [QUEUE_DEPTH];

    qptr_t   wr_ptr;
    qptr_t   rd_ptr;
    qcount_t count;

    logic    pop;

    // first word fall-through, head is always on the output
    assign item_valid = (count != '0);
    assign item       = mem[rd_ptr];
    assign pop        = item_valid && item_ready;

    // fetch keeps one read in flight and issues it from idle only,
    // so the slot it reserves is free by this registered count
    assign space = (count < qcount_t'(QUEUE_DEPTH));

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // flush drops everything in one cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own width
            if (push) begin
                wr_ptr <= wr_ptr + qptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + qptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + qcount_t'(1);
                2'b01:   count <= count - qcount_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/fetch_top.sv ====
module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  redirect_t   redirect,
    input  wb_req_t     load_req,
    input  logic        item_ready,
    output wb_rsp_t     load_rsp,
    output logic        item_valid,
    output fetch_item_t item
);

    // fetch master bus
    wb_req_t     fetch_req;
    wb_rsp_t     fetch_rsp;
    // ram side bus
    wb_req_t     ram_req;
    wb_rsp_t     ram_rsp;
    // fetch to queue
    logic        push;
    fetch_item_t push_item;
    logic        space;

    fetch_unit u_fetch (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .redirect  (redirect),
        .fetch_rsp (fetch_rsp),
        .space     (space),
        .fetch_req (fetch_req),
        .push      (push),
        .push_item (push_item)
    );

    // a redirect empties the queue in the same cycle
    fetch_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect.valid),
        .push       (push),
        .push_item  (push_item),
        .item_ready (item_ready),
        .space      (space),
        .item_valid (item_valid),
        .item       (item)
    );

    // loader has priority at cycle boundaries
    wb_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .load_req  (load_req),
        .fetch_req (fetch_req),
        .ram_rsp   (ram_rsp),
        .load_rsp  (load_rsp),
        .fetch_rsp (fetch_rsp),
        .ram_req   (ram_req)
    );

    inst_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  redirect_t   redirect,
    input  wb_rsp_t     fetch_rsp,
    input  logic        space,
    output wb_req_t     fetch_req,
    output logic        push,
    output fetch_item_t push_item
);

    fetch_state_t state;

    // next pc to fetch
    xlen_t pc;
    // address of the read on the bus, held until ack
    xlen_t req_pc;
    // redirect taken, target not yet delivered to the queue
    logic  redir_pend;

    logic  start;

    // new read only from idle, never in a redirect cycle
    assign start = (state == IDLE) && run && space && !redirect.valid;

    // cyc and stb rise with start, drop the cycle after ack
    always_comb begin
        fetch_req.cyc = start || (state != IDLE);
        fetch_req.stb = start || (state != IDLE);
        fetch_req.we  = 1'b0;
        fetch_req.dat = '0;
        fetch_req.sel = '1;
        // in idle the address is the pc itself
        if (state == IDLE) begin
            fetch_req.adr = pc;
        end else begin
            fetch_req.adr = req_pc;
        end
    end

    // response of the current path only
    // an ack in a redirect cycle belongs to the old path
    assign push = (state == WAIT_ACK) && fetch_rsp.ack && !redirect.valid;

    always_comb begin
        push_item.pc         = req_pc;
        push_item.instr      = fetch_rsp.dat;
        push_item.redirected = redir_pend;
    end

    // bus address latch, payload only
    always_ff @(posedge clk) begin
        if (start) begin
            req_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            pc         <= RESET_PC;
            redir_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (fetch_rsp.ack) begin
                        // bus cycle done either way
                        state <= IDLE;
                        if (!redirect.valid) begin
                            pc         <= pc + PC_STEP;
                            redir_pend <= 1'b0;
                        end
                    end else if (redirect.valid) begin
                        // read still open, let it finish and discard it
                        state <= DROP;
                    end
                end
                DROP: begin
                    // stale data, nothing pushed
                    if (fetch_rsp.ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            // redirect wins over the sequential step
            if (redirect.valid) begin
                pc         <= redirect.target;
                redir_pend <= 1'b1;
            end
        end
    end

endmodule

// ==== source/inst_ram.sv ====
module inst_ram import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t ram_req,
    output wb_rsp_t ram_rsp
);

    xlen_t     mem [RAM_WORDS];

    ram_addr_t idx;
    logic      access;
    logic      ack_q;
    xlen_t     rd_q;

    // word index from the byte address
    assign idx = ram_req.adr[RAM_ADDR_W+1:2];

    // a new access only when not already acking,
    // stb still high in the ack cycle must not restart
    assign access = ram_req.cyc && ram_req.stb && !ack_q;

    // byte-enabled write
    always_ff @(posedge clk) begin
        if (access && ram_req.we) begin
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (ram_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= ram_req.dat[8*b +: 8];
                end
            end
        end
    end

    // registered read, lands together with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rd_q <= mem[idx];
        end
    end

    // single-cycle ack
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_comb begin
        ram_rsp.ack = ack_q;
        ram_rsp.dat = rd_q;
    end

endmodule

// ==== source/wb_arbiter.sv ====
module wb_arbiter import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t load_req,
    input  wb_req_t fetch_req,
    input  wb_rsp_t ram_rsp,
    output wb_rsp_t load_rsp,
    output wb_rsp_t fetch_rsp,
    output wb_req_t ram_req
);

    // a granted cycle is open on the ram side
    logic busy;
    // owner of the open cycle, high for the loader
    logic owner_load;
    // current selection, loader when high
    logic sel_load;

    // between cycles the loader wins, during a cycle the owner holds
    assign sel_load = busy ? owner_load : load_req.cyc;

    // request mux
    assign ram_req = sel_load ? load_req : fetch_req;

    // ack and data only to the selected master
    always_comb begin
        load_rsp.ack  = sel_load && ram_rsp.ack;
        load_rsp.dat  = sel_load ? ram_rsp.dat : '0;
        fetch_rsp.ack = !sel_load && ram_rsp.ack;
        fetch_rsp.dat = sel_load ? '0 : ram_rsp.dat;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            owner_load <= 1'b0;
        end else if (!busy) begin
            // lock the grant at the start of a cycle
            if (ram_req.cyc) begin
                busy       <= 1'b1;
                owner_load <= sel_load;
            end
        end else if (ram_rsp.ack) begin
            // released after the ack cycle
            busy <= 1'b0;
        end
    end

endmodule
